// File: list.f
source/knight_pkg.sv
source/cmd_sequencer.sv
source/fwd_speed.sv
source/square_counter.sv
source/heading_err.sv
source/cmd_proc.sv
testbench/tb_cmd_proc.sv

// File: run_sim.sh
#!/bin/sh
# Build the knight command processor testbench with Verilator, run it and grade the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_cmd_proc \
  -f list.f -o sim_cmd_proc > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_cmd_proc > sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: testbench/cmd_vectors.txt
// Columns: test number, command word, gyro heading, IR bits {lft,cntr,rght},
// expected error one cycle after acceptance, expected fanfare_go pulses.
01 2000 000 0 000 0  // Gyro calibration.
02 6000 000 0 000 0  // Tour start, next command must be taken at once.
03 4001 010 0 010 0  // Move north one square, no nudge.
04 43F2 400 4 200 0  // Move with the left sensor on.
05 5002 020 1 E21 1  // Fanfare move with the right sensor on.
06 4C01 C00 5 1F0 0  // Both side sensors on, left wins.
07 5803 80F 0 000 1  // Fanfare move over three squares.
08 3012 000 0 FE1 0  // Unknown opcode runs as a plain move.
09 6000 000 0 000 0  // Tour start after a move.
0A 2000 000 0 000 0  // Calibration again.

// File: testbench/tb_cmd_proc.sv
////////////////////////////////////////////////////////////
// Testbench of the knight command processor.
// Reads command vectors, paces gyro readings, pulses the
// center IR sensor and checks the handshakes of each test.
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_cmd_proc;

  localparam int         MAX_TESTS   = 16;
  localparam logic [9:0] FRWRD_CEIL  = 10'h300;    // Steps of 0x20 stop once bits 9:8 are set.
  localparam int         RAMP_CYCLES = 128;        // 32 gyro readings, more than the 24 steps up.

  logic                  clk, rst_n, cmd_rdy, cal_done, heading_rdy;
  logic                  clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go;
  knight_pkg::cmd_word_t cmd;
  knight_pkg::heading_t  heading, error;
  knight_pkg::ir_t       ir;
  knight_pkg::speed_t    frwrd, frwrd_peak;        // Peak is the fastest speed seen so far.
  logic [15:0]           vec_mem [0:MAX_TESTS*6-1];   // Six columns per test.
  int                    err_cnt, test_err, fail_cnt, num_tests, timeout_limit, cyc_cnt;
  int                    resp_cnt, ff_cnt, clr_cnt;   // Running pulse totals.
  string                 cur_name;

  cmd_proc #(.FAST_SIM(1'b1)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                         // 10 ns period.
  end

  // Gyro readings arrive every 4th cycle, and the same count bounds the run.
  initial begin
    heading_rdy = 1'b0;
    forever begin
      @(posedge clk);
      cyc_cnt     <= cyc_cnt + 1;
      heading_rdy <= (cyc_cnt[1:0] == 2'b11);
    end
  end

  initial begin
    wait (timeout_limit > 0);
    while (cyc_cnt < timeout_limit) @(negedge clk);
    $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
    $display("Finished with errors");
    $finish;
  end

  // Outputs are counted on the falling edge, where they are settled.
  always @(negedge clk) begin
    resp_cnt <= resp_cnt + 32'(send_resp);
    ff_cnt   <= ff_cnt + 32'(fanfare_go);
    clr_cnt  <= clr_cnt + 32'(clr_cmd_rdy);
    if (frwrd > frwrd_peak) frwrd_peak <= frwrd;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
      err_cnt++;
      test_err++;
    end
  endtask

  // A zero field points north, any other field is centered by four one bits.
  function automatic logic [11:0] desired_heading(input logic [7:0] field);
    if (field == 8'h00) return 12'h000;
    return {field, 4'hF};
  endfunction

  ////////////////////////////////////////////////////////////
  // One test of the vector file
  ////////////////////////////////////////////////////////////
  task automatic run_test(input int idx);
    knight_pkg::cmd_t fields;
    logic             is_move;
    int               resp_base, ff_base, clr_start, clr_base;
    fields    = knight_pkg::cmd_t'(vec_mem[idx*6+1]);
    is_move   = (fields.opcode != knight_pkg::CAL) && (fields.opcode != knight_pkg::TOUR);
    cur_name  = $sformatf("test %02h", vec_mem[idx*6][7:0]);
    test_err  = 0;
    resp_base = resp_cnt;
    ff_base   = ff_cnt;
    clr_start = clr_cnt;
    @(posedge clk);
    cmd     <= vec_mem[idx*6+1];
    cmd_rdy <= 1'b1;
    heading <= vec_mem[idx*6+2][11:0];
    ir      <= knight_pkg::ir_t'(vec_mem[idx*6+3][2:0]);   // Side nudge for the error check.
    @(negedge clk);
    check_value("accepted at once", 32'd1, 32'(clr_cmd_rdy));
    check_value("strt_cal", 32'(fields.opcode == knight_pkg::CAL), 32'(strt_cal));
    check_value("tour_go", 32'(fields.opcode == knight_pkg::TOUR), 32'(tour_go));
    @(posedge clk);
    cmd_rdy <= 1'b0;
    if (fields.opcode == knight_pkg::CAL) begin
      repeat (2 + $urandom % 8) @(posedge clk);    // Calibration takes a while.
      cal_done <= 1'b1;
      @(negedge clk);
      check_value("no early send_resp", 32'(resp_base), 32'(resp_cnt));
      check_value("send_resp with cal_done", 32'd1, 32'(send_resp));
      @(posedge clk);
      cal_done <= 1'b0;
    end else if (is_move) begin
      @(negedge clk);
      check_value("error", 32'(vec_mem[idx*6+4][11:0]), 32'(error[11:0]));
      check_value("moving", 32'd1, 32'(moving));
      clr_base = clr_cnt;
      @(posedge clk);
      heading <= desired_heading(fields.hdg_field);   // Gyro settles on the target.
      ir      <= '0;
      cmd     <= 16'h6000;                         // A tour command waits through the move.
      cmd_rdy <= 1'b1;
      @(negedge clk);
      while (frwrd == '0) @(negedge clk);          // Lines only pass once the robot drives.
      repeat (RAMP_CYCLES) @(posedge clk);         // Let the ramp run into its ceiling.
      for (int i = 0; i < 2 * fields.squares; i++) begin
        @(posedge clk);
        ir.cntr <= 1'b1;
        repeat (2) @(posedge clk);
        ir.cntr <= 1'b0;
        @(posedge clk);
      end
      check_value("no send_resp before last line", 32'(resp_base), 32'(resp_cnt));
      @(negedge clk);
      while (!send_resp) @(negedge clk);
      check_value("fanfare before send_resp", 32'(vec_mem[idx*6+5]), 32'(ff_cnt - ff_base));
      check_value("pending command held", 32'(clr_base), 32'(clr_cnt));
      check_value("stopped at send_resp", 32'd0, 32'({moving, frwrd}));
      check_value("frwrd ceiling", 32'(FRWRD_CEIL), 32'(frwrd_peak));
      @(negedge clk);
      check_value("pending command taken", 32'd1, 32'(clr_cmd_rdy & tour_go));
      @(posedge clk);
      cmd_rdy <= 1'b0;
    end
    repeat (3) @(negedge clk);
    check_value("send_resp count", 32'(fields.opcode != knight_pkg::TOUR),
                32'(resp_cnt - resp_base));
    check_value("fanfare count", 32'(vec_mem[idx*6+5]), 32'(ff_cnt - ff_base));
    check_value("clr_cmd_rdy count", 32'(is_move ? 2 : 1), 32'(clr_cnt - clr_start));
    if (test_err != 0) fail_cnt++;
    $display("%s %s", cur_name, (test_err == 0) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst_n    = 1'b0;
    cmd      = '0;
    cmd_rdy  = 1'b0;
    cal_done = 1'b0;
    heading  = '0;
    ir       = '0;
    frwrd_peak = '0;
    for (int i = 0; i < MAX_TESTS * 6; i++) vec_mem[i] = '0;
    $readmemh("testbench/cmd_vectors.txt", vec_mem);
    while (num_tests < MAX_TESTS && vec_mem[num_tests*6] != 16'h0) num_tests++;
    timeout_limit = num_tests * 2000;              // Covers the longest move with margin.
    void'($urandom(32'hc537_e32c));                // Seeds the idle gaps.
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    cur_name = "reset";
    @(negedge clk);
    check_value("outputs low", 32'd0,
                32'({clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go, frwrd}));
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
      repeat (1 + $urandom % 8) @(negedge clk);
    end
    $display("Tests run %0d, tests failed %0d, check errors %0d", num_tests, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: source/cmd_proc.sv
////////////////////////////////////////////////////////////
// Top level of the knight command processor.
// Joins the sequencer, speed ramp, square counter and
// heading error blocks.
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cmd_proc #(
  parameter bit FAST_SIM = 1'b1                    // Selects the large simulation step sizes.
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  knight_pkg::cmd_word_t cmd,               // Command word, held until consumed.
  input  logic                  cmd_rdy,           // A command is waiting.
  output logic                  clr_cmd_rdy,       // The waiting command is consumed.
  output logic                  send_resp,         // Command finished, acknowledge the host.
  output logic                  strt_cal,          // Start gyro calibration.
  input  logic                  cal_done,          // Gyro calibration has finished.
  input  knight_pkg::heading_t  heading,           // Gyro heading.
  input  logic                  heading_rdy,       // One cycle strobe for a new heading.
  input  knight_pkg::ir_t       ir,                // Line sensor readings.
  output logic                  moving,            // Robot is turning or driving.
  output knight_pkg::heading_t  error,             // Heading error to the PID.
  output knight_pkg::speed_t    frwrd,             // Forward speed.
  output logic                  tour_go,           // Start the tour logic.
  output logic                  fanfare_go         // Start the charge tune.
);

  knight_pkg::cmd_t        cmd_fields;             // Command word split into its fields.
  knight_pkg::speed_ctrl_t spd_ctrl;               // Ramp commands from the sequencer.
  logic                    speed_zero;             // Forward speed has reached zero.
  logic                    move_cmd;               // Latch the move fields this cycle.
  logic                    move_done;              // All requested squares are crossed.
  logic                    aligned;                // Heading is close enough to drive.

  assign cmd_fields = knight_pkg::cmd_t'(cmd);     // Bit-for-bit view of the command.

  cmd_sequencer u_seq (
    .clk(clk), .rst_n(rst_n),
    .opcode(cmd_fields.opcode), .cmd_rdy(cmd_rdy), .cal_done(cal_done),
    .aligned(aligned), .move_done(move_done), .speed_zero(speed_zero),
    .clr_cmd_rdy(clr_cmd_rdy), .strt_cal(strt_cal), .send_resp(send_resp),
    .move_cmd(move_cmd), .spd_ctrl(spd_ctrl), .moving(moving),
    .tour_go(tour_go), .fanfare_go(fanfare_go)
  );

  fwd_speed #(.FAST_SIM(FAST_SIM)) u_speed (
    .clk(clk), .rst_n(rst_n),
    .spd_ctrl(spd_ctrl), .heading_rdy(heading_rdy),
    .frwrd(frwrd), .speed_zero(speed_zero)
  );

  square_counter u_squares (
    .clk(clk), .rst_n(rst_n),
    .cntr_ir(ir.cntr), .move_cmd(move_cmd), .squares(cmd_fields.squares),
    .move_done(move_done)
  );

  heading_err #(.FAST_SIM(FAST_SIM)) u_hdg (
    .clk(clk), .rst_n(rst_n),
    .move_cmd(move_cmd), .hdg_field(cmd_fields.hdg_field), .heading(heading),
    .lft_ir(ir.lft), .rght_ir(ir.rght),
    .error(error), .aligned(aligned)
  );

endmodule

// File: source/heading_err.sv
////////////////////////////////////////////////////////////
// Heading error for the PID. Holds the desired heading,
// adds the side IR nudge and flags alignment.
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module heading_err #(
  parameter bit FAST_SIM = 1'b1                    // Selects the large simulation nudge.
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 move_cmd,           // Load a new desired heading.
  input  logic [7:0]           hdg_field,          // Coarse heading from the command.
  input  knight_pkg::heading_t heading,            // Gyro heading.
  input  logic                 lft_ir,             // Drifted onto the left line.
  input  logic                 rght_ir,            // Drifted onto the right line.
  output knight_pkg::heading_t error,              // Error to the PID.
  output logic                 aligned             // Error magnitude is under threshold.
);

  localparam knight_pkg::heading_t NUDGE_POS =
    FAST_SIM ? knight_pkg::NUDGE_FAST : knight_pkg::NUDGE_SLOW;   // Left sensor nudge.
  localparam knight_pkg::heading_t NUDGE_NEG = -NUDGE_POS;       // Right sensor nudge.

  knight_pkg::heading_t desired_hdg;               // Heading the move should hold.
  knight_pkg::heading_t err_nudge;                 // Correction from the side sensors.
  logic [11:0]          err_mag;                   // Magnitude of the error.

  ////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_hdg <= '0;                           // North until the first move.
    end else if (move_cmd) begin
      if (hdg_field == 8'h00) begin
        desired_hdg <= '0;                         // North stays exactly zero.
      end else begin
        desired_hdg <= {hdg_field, 4'hF};          // Fill the fine bits toward the center.
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Error and alignment
  ////////////////////////////////////////////////////////////
  assign err_nudge = lft_ir  ? NUDGE_POS :         // Left sensor wins when both are on.
                     rght_ir ? NUDGE_NEG : '0;

  assign error   = heading - desired_hdg + err_nudge;
  assign err_mag = error[11] ? -error : error;     // Most negative value stays large.
  assign aligned = (err_mag < knight_pkg::ALIGN_THRESH);

endmodule

// File: source/square_counter.sv
////////////////////////////////////////////////////////////
// Square counter. Center IR rising edges are counted
// against twice the requested square count.
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module square_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cntr_ir,                      // Center line sensor.
  input  logic       move_cmd,                     // A new move starts.
  input  logic [3:0] squares,                      // Requested square count.
  output logic       move_done                     // All lines of the move are crossed.
);

  logic       cntr_prev;                           // Sensor value of the previous cycle.
  logic       line_edge;                           // Sensor went from off to on.
  logic [4:0] pulse_cnt;                           // Lines crossed in this move.
  logic [3:0] square_tgt;                          // Squares to travel in this move.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
    end else begin
      cntr_prev <= cntr_ir;
    end
  end

  assign line_edge = cntr_ir & ~cntr_prev;         // Leading edge of a line.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pulse_cnt <= '0;
    end else if (move_cmd) begin
      pulse_cnt <= '0;                             // Count afresh for each move.
    end else if (line_edge) begin
      pulse_cnt <= pulse_cnt + 5'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      square_tgt <= '0;
    end else if (move_cmd) begin
      square_tgt <= squares;
    end
  end

  // Each square shows two lines, hence the doubled target.
  assign move_done = (pulse_cnt == {square_tgt, 1'b0});

endmodule

// File: source/fwd_speed.sv
////////////////////////////////////////////////////////////
// Forward speed register with ramp up and ramp down steps.
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fwd_speed #(
  parameter bit FAST_SIM = 1'b1                    // Selects the large simulation steps.
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  knight_pkg::speed_ctrl_t spd_ctrl,        // Clear, ramp up or ramp down.
  input  logic                    heading_rdy,     // Ramp steps are paced by gyro readings.
  output knight_pkg::speed_t      frwrd,           // Forward speed.
  output logic                    speed_zero       // Speed is at standstill.
);

  localparam knight_pkg::speed_t INC_STEP =
    FAST_SIM ? knight_pkg::INC_FAST : knight_pkg::INC_SLOW;   // Ramp up step.
  localparam knight_pkg::speed_t DEC_STEP =
    FAST_SIM ? knight_pkg::DEC_FAST : knight_pkg::DEC_SLOW;   // Ramp down step.

  logic at_max;                                    // Both top bits set means full speed.

  assign at_max     = &frwrd[9:8];
  assign speed_zero = (frwrd == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (spd_ctrl.clr) begin
      frwrd <= '0;                                 // Every ramp starts from rest.
    end else if (heading_rdy) begin
      if (spd_ctrl.inc && !at_max) begin
        frwrd <= frwrd + INC_STEP;                 // Step up until the ceiling.
      end else if (spd_ctrl.dec) begin
        frwrd <= (frwrd > DEC_STEP) ? frwrd - DEC_STEP : '0;   // Floor at zero.
      end
    end
  end

  // The sequencer issues at most one ramp command per state.
  a_one_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(spd_ctrl));

endmodule

// File: source/cmd_sequencer.sv
////////////////////////////////////////////////////////////
// Command FSM of the knight robot.
// Dispatches commands, waits on gyro calibration and steps
// each move through align, ramp up and ramp down.
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cmd_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  knight_pkg::opcode_t     opcode,          // Opcode of the waiting command.
  input  logic                    cmd_rdy,         // A command is waiting.
  input  logic                    cal_done,        // Gyro calibration has finished.
  input  logic                    aligned,         // Heading error is under threshold.
  input  logic                    move_done,       // Last square line is crossed.
  input  logic                    speed_zero,      // Ramp down has finished.
  output logic                    clr_cmd_rdy,     // Consume the waiting command.
  output logic                    strt_cal,        // One cycle calibration start.
  output logic                    send_resp,       // One cycle command complete.
  output logic                    move_cmd,        // Load heading and square count.
  output knight_pkg::speed_ctrl_t spd_ctrl,        // Ramp commands to the speed register.
  output logic                    moving,          // Robot is turning or driving.
  output logic                    tour_go,         // One cycle tour start.
  output logic                    fanfare_go       // One cycle tune start.
);

  knight_pkg::seq_state_t state;                   // Present state.
  knight_pkg::seq_state_t nxt_state;               // State for the next cycle.
  logic                   fanfare_move;            // The running move ends with the tune.

  ////////////////////////////////////////////////////////////
  // State register and move flavour
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= knight_pkg::IDLE;                   // Wake up waiting for a command.
    end else begin
      state <= nxt_state;
    end
  end

  // The command word may change once consumed, so remember the flavour here.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fanfare_move <= 1'b0;
    end else if (move_cmd) begin
      fanfare_move <= (opcode == knight_pkg::FANFARE);   // Only FANFARE plays at the end.
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state   = state;                           // Hold by default.
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    move_cmd    = 1'b0;
    spd_ctrl    = '0;                              // No ramp activity by default.
    moving      = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    case (state)
      knight_pkg::CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;                        // Acknowledge in the cycle done is seen.
          nxt_state = knight_pkg::IDLE;
        end
      end
      knight_pkg::MOVE: begin
        moving = 1'b1;                             // Turning in place counts as moving.
        if (aligned) begin
          spd_ctrl.clr = 1'b1;                     // Start the ramp from standstill.
          nxt_state    = knight_pkg::INCR;
        end
      end
      knight_pkg::INCR: begin
        moving       = 1'b1;
        spd_ctrl.inc = 1'b1;                       // Ramp up until the ceiling.
        if (move_done) begin
          fanfare_go = fanfare_move;               // Tune starts as the last line passes.
          nxt_state  = knight_pkg::DECR;
        end
      end
      knight_pkg::DECR: begin
        spd_ctrl.dec = 1'b1;                       // Ramp down to a stop.
        if (speed_zero) begin
          send_resp = 1'b1;                        // Move is over once stopped.
          nxt_state = knight_pkg::IDLE;
        end else begin
          moving = 1'b1;
        end
      end
      default: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;                      // Every opcode is consumed at once.
          case (opcode)
            knight_pkg::TOUR: begin
              tour_go = 1'b1;                      // Stay idle while the tour runs.
            end
            knight_pkg::CAL: begin
              strt_cal  = 1'b1;
              nxt_state = knight_pkg::CALIBRATE;
            end
            default: begin
              move_cmd  = 1'b1;                    // Unknown opcodes run as plain moves.
              nxt_state = knight_pkg::MOVE;
            end
          endcase
        end
      end
    endcase
  end

  // Commands are only consumed while idle, so a busy move leaves cmd_rdy pending.
  a_clr_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |-> state == knight_pkg::IDLE);

  // The tune starts when speed is still up, well before the response.
  a_fanfare_not_resp: assert property (@(posedge clk) disable iff (!rst_n)
    !(fanfare_go && send_resp));

endmodule

// File: source/knight_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions of the knight command processor.
// Widths, command fields, opcodes, state encoding, the
// speed control and IR bundles, and the step constants.
////////////////////////////////////////////////////////////
package knight_pkg;

  typedef logic [15:0]        cmd_word_t;   // Raw command word from the wireless link.
  typedef logic signed [11:0] heading_t;    // Gyro heading and the error sent to the PID.
  typedef logic [9:0]         speed_t;      // Forward speed handed to the motor drive.

  // Opcodes keep the encoding of the command protocol.
  typedef enum logic [3:0] {
    CAL     = 4'b0010,                      // Calibrate the gyro.
    MOV     = 4'b0100,                      // Plain move.
    FANFARE = 4'b0101,                      // Move and play the charge tune at the end.
    TOUR    = 4'b0110                       // Hand control to the tour logic.
  } opcode_t;

  typedef struct packed {
    opcode_t    opcode;                     // Top nibble selects the command.
    logic [7:0] hdg_field;                  // Coarse heading of a move.
    logic [3:0] squares;                    // Number of squares to travel.
  } cmd_t;

  typedef struct packed {
    logic clr;                              // Zero the speed before a ramp.
    logic inc;                              // Ramp up on each heading reading.
    logic dec;                              // Ramp down on each heading reading.
  } speed_ctrl_t;

  typedef struct packed {
    logic lft;                              // Left line sensor.
    logic cntr;                             // Center line sensor, used for square counting.
    logic rght;                             // Right line sensor.
  } ir_t;

  typedef enum logic [2:0] {IDLE, CALIBRATE, MOVE, INCR, DECR} seq_state_t;

  localparam logic [11:0] ALIGN_THRESH = 12'h02C;   // Error magnitude that counts as aligned.

  localparam speed_t INC_FAST = 10'h020;    // Large ramp steps shorten simulation.
  localparam speed_t INC_SLOW = 10'h003;
  localparam speed_t DEC_FAST = 10'h040;
  localparam speed_t DEC_SLOW = 10'h006;

  localparam heading_t NUDGE_FAST = 12'sh1FF;   // Negative nudges are the exact negation.
  localparam heading_t NUDGE_SLOW = 12'sh05F;

endpackage
